//--- compile.f
src/cpuPkg.sv
src/instMem.sv
src/decoder.sv
src/regFile.sv
src/alu.sv
src/hazardUnit.sv
src/dataMem.sv
src/cpu.sv
verification/clkGen.sv
verification/cpuTb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f compile.f -o cpuSim \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/cpuSim > sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "Regression passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation finished, see sim.log"

//--- src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  cpuPkg::aluOp_e op,
	input  logic [31:0]    a,
	input  logic [31:0]    b,
	input  logic [4:0]     shamt,
	output logic [31:0]    result,
	output logic           zero
);
	import cpuPkg::*;

	always_comb begin
		case (op)
			aluAnd: begin
				result = a & b;
			end
			aluOr: begin
				result = a | b;
			end
			// Wraps modulo 2^32
			aluAdd: begin
				result = a + b;
			end
			aluSub: begin
				result = a - b;
			end
			aluSltS: begin
				result = {31'd0, $signed(a) < $signed(b)};
			end
			aluSltU: begin
				result = {31'd0, a < b};
			end
			// sll takes the rt operand, not rs
			aluSll: begin
				result = b << shamt;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

//--- src/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu (
	input  logic                           clk,
	input  logic                           rstN,
	input  logic                           progWe,
	input  logic [cpuPkg::memAddrBits-1:0] progAddr,
	input  logic [31:0]                    progData,
	output cpuPkg::retire_s                retire,
	output cpuPkg::store_s                 store
);
	import cpuPkg::*;

	logic [31:0]            pc;
	logic [31:0]            pcPlus4;
	ifId_s                  ifId;
	ifId_s                  ifIdNext;
	idEx_s                  idEx;
	idEx_s                  idExNext;
	exMem_s                 exMem;
	exMem_s                 exMemNext;
	memWb_s                 memWb;
	memWb_s                 memWbNext;
	instWord_u              fetchWord;
	instWord_u              fetchInst;
	instWord_u              idInst;
	ctrl_s                  idCtrl;
	logic [31:0]            busA;
	logic [31:0]            busB;
	logic                   stall;
	logic                   flush;
	fwdSel_e                fwdA;
	fwdSel_e                fwdB;
	logic [31:0]            opA;
	logic [31:0]            opB;
	logic [31:0]            aluB;
	logic [31:0]            aluOut;
	logic                   aluZero;
	logic                   branchTaken;
	logic [31:0]            branchTarget;
	logic [4:0]             exRw;
	logic                   memWe;
	logic [memAddrBits-1:0] memIndex;
	logic [31:0]            memRdata;
	logic                   regWe;
	logic [31:0]            wbData;

	function automatic logic [31:0] fwdMux(
		input fwdSel_e     sel,
		input logic [31:0] regVal,
		input logic [31:0] exMemVal,
		input logic [31:0] memWbVal
	);
		case (sel)
			fwdExMem: return exMemVal;
			fwdMemWb: return memWbVal;
			default:  return regVal;
		endcase
	endfunction

	// Fetch
	assign pcPlus4 = pc + 32'd4;

	instMem uInstMem (
		.clk,
		.progWe,
		.progAddr,
		.progData,
		.pcIndex (pc[memAddrBits+1:2]),
		.inst    (fetchWord)
	);

	// Past the end of instruction memory, fetch nops instead of wrapping
	assign fetchInst = (pc[31:memAddrBits+2] == '0) ? fetchWord : '0;

	always_comb begin
		ifIdNext.valid   = 1'b1;
		ifIdNext.pcPlus4 = pcPlus4;
		ifIdNext.inst    = fetchInst;
	end

	// Decode
	assign idInst = ifId.inst;

	decoder uDecoder (
		.inst (idInst),
		.ctrl (idCtrl)
	);

	regFile uRegFile (
		.clk,
		.rstN,
		.ra   (idInst.rType.rs),
		.rb   (idInst.rType.rt),
		.busA,
		.busB,
		.we   (regWe),
		.rw   (memWb.rw),
		.busW (wbData)
	);

	always_comb begin
		idExNext.valid = ifId.valid;
		idExNext.ctrl  = '0;
		if (ifId.valid) begin
			idExNext.ctrl = idCtrl;
		end
		idExNext.pcPlus4 = ifId.pcPlus4;
		idExNext.busA    = busA;
		idExNext.busB    = busB;
		idExNext.rs      = idInst.rType.rs;
		idExNext.rt      = idInst.rType.rt;
		idExNext.rd      = idInst.rType.rd;
		idExNext.shamt   = idInst.rType.shamt;
		idExNext.imm32   = {{16{idInst.iType.imm16[15]}}, idInst.iType.imm16};
	end

	hazardUnit uHazardUnit (
		.idRs  (idInst.rType.rs),
		.idRt  (idInst.rType.rt),
		.idEx,
		.exMem,
		.memWb,
		.branchTaken,
		.stall,
		.flush,
		.fwdA,
		.fwdB
	);

	// Execute
	assign opA  = fwdMux(fwdA, idEx.busA, exMem.aluOut, wbData);
	assign opB  = fwdMux(fwdB, idEx.busB, exMem.aluOut, wbData);
	assign aluB = idEx.ctrl.aluSrc ? idEx.imm32 : opB;

	alu uAlu (
		.op     (idEx.ctrl.aluOp),
		.a      (opA),
		.b      (aluB),
		.shamt  (idEx.shamt),
		.result (aluOut),
		.zero   (aluZero)
	);

	// bgtz looks at rs alone
	assign branchTaken = idEx.valid && ((idEx.ctrl.branchEq && aluZero)
		|| (idEx.ctrl.branchNe && !aluZero)
		|| (idEx.ctrl.branchGtz && ($signed(opA) > 32'sd0)));
	assign branchTarget = idEx.pcPlus4 + {idEx.imm32[29:0], 2'b00};
	assign exRw         = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

	always_comb begin
		exMemNext.valid     = idEx.valid;
		exMemNext.regWr     = idEx.valid && idEx.ctrl.regWr;
		exMemNext.memWr     = idEx.valid && idEx.ctrl.memWr;
		exMemNext.memToReg  = idEx.valid && idEx.ctrl.memToReg;
		exMemNext.rw        = exRw;
		exMemNext.aluOut    = aluOut;
		exMemNext.storeData = opB;
	end

	// Memory, byte address bits 7 to 2 pick the word
	assign memWe    = exMem.valid && exMem.memWr;
	assign memIndex = exMem.aluOut[memAddrBits+1:2];

	dataMem uDataMem (
		.clk,
		.we    (memWe),
		.addr  (memIndex),
		.wdata (exMem.storeData),
		.rdata (memRdata)
	);

	always_comb begin
		memWbNext.valid    = exMem.valid;
		memWbNext.regWr    = exMem.valid && exMem.regWr;
		memWbNext.memToReg = exMem.memToReg;
		memWbNext.rw       = exMem.rw;
		memWbNext.aluOut   = exMem.aluOut;
		memWbNext.memData  = memRdata;
	end

	// Write-back
	assign regWe  = memWb.valid && memWb.regWr;
	assign wbData = memWb.memToReg ? memWb.memData : memWb.aluOut;

	always_comb begin
		retire.valid = regWe && (memWb.rw != 5'd0);
		retire.rw    = memWb.rw;
		retire.data  = wbData;
		store.valid  = memWe;
		store.addr   = memIndex;
		store.data   = exMem.storeData;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc    <= '0;
			ifId  <= '0;
			idEx  <= '0;
			exMem <= '0;
			memWb <= '0;
		end else begin
			exMem <= exMemNext;
			memWb <= memWbNext;
			if (flush) begin
				// Kill the two younger instructions
				pc   <= branchTarget;
				ifId <= '0;
				idEx <= '0;
			end else if (stall) begin
				// PC and ifId hold, bubble into execute
				idEx <= '0;
			end else begin
				pc   <= pcPlus4;
				ifId <= ifIdNext;
				idEx <= idExNext;
			end
		end
	end

	// The bubble a stall inserts can never cause a second stall
	stallOneCycle: assert property (@(posedge clk) disable iff (!rstN)
		stall |=> !stall);

	branchKindOneHot: assert property (@(posedge clk) disable iff (!rstN)
		$onehot0({idEx.ctrl.branchEq, idEx.ctrl.branchNe, idEx.ctrl.branchGtz}));

endmodule

`default_nettype wire

//--- src/cpuPkg.sv
`default_nettype none

package cpuPkg;

	localparam int memDepth    = 64;
	localparam int memAddrBits = 6;

	// Primary opcodes
	localparam logic [5:0] opRType = 6'b000000;
	localparam logic [5:0] opAddi  = 6'b001000;
	localparam logic [5:0] opLw    = 6'b100011;
	localparam logic [5:0] opSw    = 6'b101011;
	localparam logic [5:0] opBeq   = 6'b000100;
	localparam logic [5:0] opBne   = 6'b000101;
	localparam logic [5:0] opBgtz  = 6'b000111;

	// R-type function codes
	localparam logic [5:0] fnAdd  = 6'b100000;
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSub  = 6'b100010;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnAnd  = 6'b100100;
	localparam logic [5:0] fnOr   = 6'b100101;
	localparam logic [5:0] fnSll  = 6'b000000;
	localparam logic [5:0] fnSlt  = 6'b101010;
	localparam logic [5:0] fnSltu = 6'b101011;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rType_s;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} iType_s;

	// Same 32 bits seen as register form or immediate form
	typedef union packed {
		rType_s rType;
		iType_s iType;
	} instWord_u;

	// Encoding 3'd4 is left unused
	typedef enum logic [2:0] {
		aluAnd  = 3'd0,
		aluOr   = 3'd1,
		aluAdd  = 3'd2,
		aluSltS = 3'd3,
		aluSll  = 3'd5,
		aluSub  = 3'd6,
		aluSltU = 3'd7
	} aluOp_e;

	typedef struct packed {
		logic   regWr;
		logic   regDst;
		logic   aluSrc;
		logic   memWr;
		logic   memToReg;
		logic   branchEq;
		logic   branchNe;
		logic   branchGtz;
		aluOp_e aluOp;
	} ctrl_s;

	typedef enum logic [1:0] {
		fwdNone,
		fwdExMem,
		fwdMemWb
	} fwdSel_e;

	typedef struct packed {
		logic        valid;
		logic [31:0] pcPlus4;
		instWord_u   inst;
	} ifId_s;

	typedef struct packed {
		logic        valid;
		ctrl_s       ctrl;
		logic [31:0] pcPlus4;
		logic [31:0] busA;
		logic [31:0] busB;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  shamt;
		logic [31:0] imm32;
	} idEx_s;

	typedef struct packed {
		logic        valid;
		logic        regWr;
		logic        memWr;
		logic        memToReg;
		logic [4:0]  rw;
		logic [31:0] aluOut;
		logic [31:0] storeData;
	} exMem_s;

	typedef struct packed {
		logic        valid;
		logic        regWr;
		logic        memToReg;
		logic [4:0]  rw;
		logic [31:0] aluOut;
		logic [31:0] memData;
	} memWb_s;

	typedef struct packed {
		logic        valid;
		logic [4:0]  rw;
		logic [31:0] data;
	} retire_s;

	typedef struct packed {
		logic                   valid;
		logic [memAddrBits-1:0] addr;
		logic [31:0]            data;
	} store_s;

endpackage

`default_nettype wire

//--- src/dataMem.sv
`timescale 1ns/1ps
`default_nettype none

module dataMem (
	input  logic                           clk,
	input  logic                           we,
	input  logic [cpuPkg::memAddrBits-1:0] addr,
	input  logic [31:0]                    wdata,
	output logic [31:0]                    rdata
);
	import cpuPkg::*;

	logic [31:0] mem [memDepth];

	initial begin
		for (int i = 0; i < memDepth; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	assign rdata = mem[addr];

	addrKnownOnWrite: assert property (@(posedge clk) we |-> !$isunknown(addr));

endmodule

`default_nettype wire

//--- src/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input  cpuPkg::instWord_u inst,
	output cpuPkg::ctrl_s     ctrl
);
	import cpuPkg::*;

	always_comb begin
		ctrl = '0;
		case (inst.iType.op)
			opRType: begin
				ctrl.regWr  = 1'b1;
				ctrl.regDst = 1'b1;
				case (inst.rType.funct)
					// No overflow trap, so both adds behave alike
					fnAdd, fnAddu: begin
						ctrl.aluOp = aluAdd;
					end
					fnSub, fnSubu: begin
						ctrl.aluOp = aluSub;
					end
					fnAnd: begin
						ctrl.aluOp = aluAnd;
					end
					fnOr: begin
						ctrl.aluOp = aluOr;
					end
					fnSll: begin
						ctrl.aluOp = aluSll;
					end
					fnSlt: begin
						ctrl.aluOp = aluSltS;
					end
					fnSltu: begin
						ctrl.aluOp = aluSltU;
					end
					// Unknown function code is a nop
					default: begin
						ctrl = '0;
					end
				endcase
			end
			opAddi: begin
				ctrl.regWr  = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp  = aluAdd;
			end
			opLw: begin
				ctrl.regWr    = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluOp    = aluAdd;
			end
			opSw: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memWr  = 1'b1;
				ctrl.aluOp  = aluAdd;
			end
			// Branches compare through the subtractor's zero flag
			opBeq: begin
				ctrl.branchEq = 1'b1;
				ctrl.aluOp    = aluSub;
			end
			opBne: begin
				ctrl.branchNe = 1'b1;
				ctrl.aluOp    = aluSub;
			end
			opBgtz: begin
				ctrl.branchGtz = 1'b1;
				ctrl.aluOp     = aluSub;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- src/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	input  logic [4:0]      idRs,
	input  logic [4:0]      idRt,
	input  cpuPkg::idEx_s   idEx,
	input  cpuPkg::exMem_s  exMem,
	input  cpuPkg::memWb_s  memWb,
	input  logic            branchTaken,
	output logic            stall,
	output logic            flush,
	output cpuPkg::fwdSel_e fwdA,
	output cpuPkg::fwdSel_e fwdB
);
	import cpuPkg::*;

	logic       exMemLive;
	logic       memWbLive;
	logic [4:0] idExRw;
	logic       loadUse;

	// A stage is a forwarding source only if it writes a real register
	assign exMemLive = exMem.valid && exMem.regWr && (exMem.rw != 5'd0);
	assign memWbLive = memWb.valid && memWb.regWr && (memWb.rw != 5'd0);

	// Younger result wins
	always_comb begin
		fwdA = fwdNone;
		if (exMemLive && (exMem.rw == idEx.rs)) begin
			fwdA = fwdExMem;
		end else if (memWbLive && (memWb.rw == idEx.rs)) begin
			fwdA = fwdMemWb;
		end
		fwdB = fwdNone;
		if (exMemLive && (exMem.rw == idEx.rt)) begin
			fwdB = fwdExMem;
		end else if (memWbLive && (memWb.rw == idEx.rt)) begin
			fwdB = fwdMemWb;
		end
	end

	assign idExRw = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

	// Load data shows up one stage too late for the next instruction
	assign loadUse = idEx.valid && idEx.ctrl.memToReg && idEx.ctrl.regWr
		&& (idExRw != 5'd0) && ((idExRw == idRs) || (idExRw == idRt));

	assign flush = branchTaken;
	assign stall = loadUse && !branchTaken;

endmodule

`default_nettype wire

//--- src/instMem.sv
`timescale 1ns/1ps
`default_nettype none

module instMem (
	input  logic                           clk,
	input  logic                           progWe,
	input  logic [cpuPkg::memAddrBits-1:0] progAddr,
	input  logic [31:0]                    progData,
	input  logic [cpuPkg::memAddrBits-1:0] pcIndex,
	output cpuPkg::instWord_u              inst
);
	import cpuPkg::*;

	logic [31:0] mem [memDepth];

	// Unloaded words read as sll r0, a nop
	initial begin
		for (int i = 0; i < memDepth; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (progWe) begin
			mem[progAddr] <= progData;
		end
	end

	assign inst = mem[pcIndex];

endmodule

`default_nettype wire

//--- src/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  logic        clk,
	input  logic        rstN,
	input  logic [4:0]  ra,
	input  logic [4:0]  rb,
	output logic [31:0] busA,
	output logic [31:0] busB,
	input  logic        we,
	input  logic [4:0]  rw,
	input  logic [31:0] busW
);
	logic [31:0] regs [32];
	logic        wrLive;

	// r0 is never written, so it keeps its reset value
	assign wrLive = we && (rw != 5'd0);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrLive) begin
			regs[rw] <= busW;
		end
	end

	// Write-first so write-back feeds decode in the same cycle
	assign busA = (wrLive && (rw == ra)) ? busW : regs[ra];
	assign busB = (wrLive && (rw == rb)) ? busW : regs[rb];

	r0ReadsZero: assert property (@(posedge clk) disable iff (!rstN)
		((ra != 5'd0) || (busA == '0)) && ((rb != 5'd0) || (busB == '0)));

endmodule

`default_nettype wire

//--- verification/clkGen.sv
`timescale 1ns/1ps
`default_nettype none

module clkGen (
	input  logic holdReset,
	output logic clk,
	output logic rstN
);
	logic       held;
	logic [1:0] relCount;

	initial begin
		clk      = 1'b0;
		rstN     = 1'b0;
		held     = 1'b1;
		relCount = 2'd0;
	end

	always #50 clk = ~clk;

	// Reset stays low while the program loads, then two more cycles
	always @(posedge clk) begin
		held = holdReset;
		#1;
		if (held) begin
			relCount = 2'd0;
			rstN     = 1'b0;
		end else if (relCount != 2'd2) begin
			relCount = relCount + 2'd1;
			rstN     = (relCount == 2'd2);
		end
	end

endmodule

`default_nettype wire

//--- verification/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
	import cpuPkg::*;

	localparam int progLen     = 48;
	localparam int runTimeout  = 2000;
	localparam int drainCycles = 12;

	logic                   clk;
	logic                   rstN;
	logic                   holdReset;
	logic                   progWe;
	logic [memAddrBits-1:0] progAddr;
	logic [31:0]            progData;
	retire_s                retire;
	store_s                 store;

	logic [31:0] lfsrState;
	logic [31:0] prog [progLen];
	logic [31:0] modelRegs [32];
	logic [31:0] modelMem [memDepth];
	retire_s     retireQ [$];
	store_s      storeQ [$];
	int          cycleNum;

	clkGen uClkGen (
		.holdReset,
		.clk,
		.rstN
	);

	cpu u_dut (
		.clk,
		.rstN,
		.progWe,
		.progAddr,
		.progData,
		.retire,
		.store
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] drawBits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			val       = {val[30:0], lfsrState[0]};
		end
		return val;
	endfunction

	// Registers r0 to r7 only, so neighbours often depend on each other
	function automatic logic [31:0] randomInst();
		instWord_u  w;
		logic [3:0] kind;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		kind = 4'(drawBits(4));
		rs   = 5'(drawBits(3));
		rt   = 5'(drawBits(3));
		rd   = 5'(drawBits(3));
		w    = '0;
		if (kind < 4'd9) begin
			w.rType.op = opRType;
			w.rType.rs = rs;
			w.rType.rt = rt;
			w.rType.rd = rd;
			case (kind)
				4'd0: w.rType.funct = fnAdd;
				4'd1: w.rType.funct = fnAddu;
				4'd2: w.rType.funct = fnSub;
				4'd3: w.rType.funct = fnSubu;
				4'd4: w.rType.funct = fnAnd;
				4'd5: w.rType.funct = fnOr;
				4'd6: w.rType.funct = fnSlt;
				4'd7: w.rType.funct = fnSltu;
				default: begin
					w.rType.funct = fnSll;
					w.rType.rs    = 5'd0;
					w.rType.shamt = 5'(drawBits(5));
				end
			endcase
		end else begin
			w.iType.rs = rs;
			w.iType.rt = rt;
			case (kind)
				// Base r0, a small window of words so loads hit earlier stores
				4'd10, 4'd11: begin
					w.iType.op    = (kind == 4'd10) ? opLw : opSw;
					w.iType.rs    = 5'd0;
					w.iType.imm16 = 16'(drawBits(4) << 2);
				end
				4'd12, 4'd13: begin
					w.iType.op    = (kind == 4'd12) ? opBeq : opBne;
					w.iType.imm16 = 16'(drawBits(2));
				end
				4'd14: begin
					w.iType.op    = opBgtz;
					w.iType.rt    = 5'd0;
					w.iType.imm16 = 16'(drawBits(2));
				end
				default: begin
					w.iType.op    = opAddi;
					w.iType.imm16 = 16'(drawBits(16));
				end
			endcase
		end
		return w;
	endfunction

	// Sequential interpreter, one instruction at a time
	task automatic runModel();
		instWord_u   w;
		int          pcIdx;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm32;
		logic [31:0] addr;
		logic [31:0] res;
		logic [4:0]  dest;
		logic        wr;
		logic        taken;
		retire_s     r;
		store_s      s;
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		for (int i = 0; i < memDepth; i++) begin
			modelMem[i] = '0;
		end
		pcIdx = 0;
		while (pcIdx < progLen) begin
			w     = prog[pcIdx];
			a     = modelRegs[w.rType.rs];
			b     = modelRegs[w.rType.rt];
			imm32 = {{16{w.iType.imm16[15]}}, w.iType.imm16};
			addr  = a + imm32;
			dest  = w.iType.rt;
			res   = '0;
			wr    = 1'b0;
			taken = 1'b0;
			case (w.iType.op)
				opRType: begin
					wr   = 1'b1;
					dest = w.rType.rd;
					case (w.rType.funct)
						fnAdd, fnAddu: res = a + b;
						fnSub, fnSubu: res = a - b;
						fnAnd: res = a & b;
						fnOr: res = a | b;
						fnSll: res = b << w.rType.shamt;
						fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						fnSltu: res = (a < b) ? 32'd1 : 32'd0;
						default: wr = 1'b0;
					endcase
				end
				opAddi: begin
					wr  = 1'b1;
					res = addr;
				end
				opLw: begin
					wr  = 1'b1;
					res = modelMem[addr[7:2]];
				end
				opSw: begin
					modelMem[addr[7:2]] = b;
					s.valid = 1'b1;
					s.addr  = addr[7:2];
					s.data  = b;
					storeQ.push_back(s);
				end
				opBeq: taken = (a == b);
				opBne: taken = (a != b);
				opBgtz: taken = ($signed(a) > 32'sd0);
				default: wr = 1'b0;
			endcase
			// Writes to r0 vanish
			if (wr && (dest != 5'd0)) begin
				modelRegs[dest] = res;
				r.valid = 1'b1;
				r.rw    = dest;
				r.data  = res;
				retireQ.push_back(r);
			end
			pcIdx = taken ? pcIdx + 1 + int'(w.iType.imm16) : pcIdx + 1;
		end
	endtask

	task automatic failRun();
		$display("Regression failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic checkRetire(input retire_s got);
		retire_s want;
		if (retireQ.size() == 0) begin
			$display("Retire of r%0d = %h after the model's last register write", got.rw, got.data);
			failRun();
		end else begin
			want = retireQ.pop_front();
			if (got.rw !== want.rw) begin
				$display("CHECK FAILED retire.rw got %h expected %h", got.rw, want.rw);
				failRun();
			end else if (got.data !== want.data) begin
				$display("CHECK FAILED retire.data got %h expected %h", got.data, want.data);
				failRun();
			end
		end
	endtask

	task automatic checkStore(input store_s got);
		store_s want;
		if (storeQ.size() == 0) begin
			$display("Store to word %0d after the model's last store", got.addr);
			failRun();
		end else begin
			want = storeQ.pop_front();
			if (got.addr !== want.addr) begin
				$display("CHECK FAILED store.addr got %h expected %h", got.addr, want.addr);
				failRun();
			end else if (got.data !== want.data) begin
				$display("CHECK FAILED store.data got %h expected %h", got.data, want.data);
				failRun();
			end
		end
	endtask

	task automatic checkIdle();
		if (retire.valid || store.valid) begin
			$display("Retire or store strobe while the core is held in reset");
			failRun();
		end
	endtask

	// First fetch is cycle 1, its store shows in cycle 4, its write-back in cycle 5
	task automatic sampleEvents();
		if (retire.valid && (cycleNum < 5)) begin
			$display("Retire in cycle %0d, before any instruction reached write-back", cycleNum);
			failRun();
		end else if (store.valid && (cycleNum < 4)) begin
			$display("Store in cycle %0d, before any instruction reached memory", cycleNum);
			failRun();
		end else begin
			if (retire.valid) begin
				checkRetire(retire);
			end
			if (store.valid) begin
				checkStore(store);
			end
		end
	endtask

	task automatic waitForRelease();
		int waitCount;
		waitCount = 0;
		while (!rstN && (waitCount < 10)) begin
			@(negedge clk);
			if (!rstN) begin
				checkIdle();
			end
			waitCount++;
		end
		if (!rstN) begin
			$display("Reset was not released within 10 cycles of the program load");
			failRun();
		end
	endtask

	initial begin
		int waitCount;
		holdReset = 1'b1;
		progWe    = 1'b0;
		progAddr  = '0;
		progData  = '0;
		lfsrState = 32'hfc02_965d;
		cycleNum  = 0;
		for (int i = 0; i < progLen; i++) begin
			prog[i] = randomInst();
		end
		runModel();
		$display("Expecting %0d retires and %0d stores", retireQ.size(), storeQ.size());

		// Program goes in while the pipeline is held in reset
		for (int i = 0; i < progLen; i++) begin
			@(posedge clk);
			#1;
			progWe   = 1'b1;
			progAddr = i[memAddrBits-1:0];
			progData = prog[i];
			@(negedge clk);
			checkIdle();
		end
		@(posedge clk);
		#1;
		progWe    = 1'b0;
		holdReset = 1'b0;
		waitForRelease();

		cycleNum  = 1;
		waitCount = 0;
		while (((retireQ.size() != 0) || (storeQ.size() != 0)) && (waitCount < runTimeout)) begin
			sampleEvents();
			@(negedge clk);
			cycleNum++;
			waitCount++;
		end
		if ((retireQ.size() != 0) || (storeQ.size() != 0)) begin
			$display("Timed out after %0d cycles with %0d retires and %0d stores outstanding",
				waitCount, retireQ.size(), storeQ.size());
			failRun();
		end else begin
			// Nops past the program must stay silent
			for (int i = 0; i < drainCycles; i++) begin
				sampleEvents();
				@(negedge clk);
				cycleNum++;
			end
			$display("Regression passed");
			$finish;
		end
	end

endmodule

`default_nettype wire
